//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_maze_node
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "No result line in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/ingress_port.sv
// Route is combinational from the head packet and pg inputs; only unicast is assumed
`include "maze_node_config.svh"

module ingress_port #(
    parameter bit                    IS_LOCAL = 1'b0,  // 1 = A port rule
    parameter maze_node_pkg::coord_t HP       = `MAZE_DEF_HP,
    parameter maze_node_pkg::coord_t VP       = `MAZE_DEF_VP
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      in_vld_i,
    input  maze_node_pkg::pkt_t       in_pkt_i,
    output logic                      in_rdy_o,
    input  logic                      pg_en_i,
    input  maze_node_pkg::node_t      pg_node_i,
    output logic                      head_vld_o,
    output maze_node_pkg::pkt_t       head_pkt_o,
    output maze_node_pkg::out_port_e  head_dest_o,
    input  logic                      pop_i
);

    import maze_node_pkg::*;

    localparam node_t SELF = {VP, HP};

    coord_t tgt_x;       // Target column
    coord_t tgt_y;       // Target row
    node_t  mid1;        // Same row, target column
    node_t  mid2;        // Target row, same column
    logic   mid1_gated;
    logic   mid2_gated;
    logic   col_diff;    // Target not in this column

    // ======================================================================
    // Input buffer
    // ======================================================================

    pkt_fifo #(
        .DEPTH(`MAZE_IN_DEPTH)
    ) u_buf (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wr_vld_i (in_vld_i),
        .wr_pkt_i (in_pkt_i),
        .wr_rdy_o (in_rdy_o),
        .rd_vld_o (head_vld_o),
        .rd_pkt_o (head_pkt_o),
        .rd_rdy_i (pop_i),      // Switch pops only a valid head
        .full_o   ()
    );

    // ======================================================================
    // Route of the head packet
    // ======================================================================

    assign tgt_x = head_pkt_o.tgt[`MAZE_COORD_W-1:0];
    assign tgt_y = head_pkt_o.tgt[`MAZE_NODE_W-1:`MAZE_COORD_W];

    assign mid1 = {VP, tgt_x};
    assign mid2 = {tgt_y, HP};

    assign mid1_gated = pg_en_i && (pg_node_i == mid1);
    assign mid2_gated = pg_en_i && (pg_node_i == mid2);
    assign col_diff   = (tgt_x != HP);

    always_comb begin
        if (head_pkt_o.tgt == SELF) begin
            head_dest_o = OUT_B;                        // Arrived
        end else if (IS_LOCAL && !mid1_gated) begin
            head_dest_o = col_diff ? OUT_X : OUT_Y;     // Towards first detour node
        end else if (IS_LOCAL && !mid2_gated) begin
            head_dest_o = OUT_Y;                        // Second node shares our column
        end else begin
            // Direct path, also the plain link rule
            head_dest_o = col_diff ? OUT_X : OUT_Y;
        end
    end

endmodule

//--- hdl/maze_node.sv
// One X and one Y link pair only; pg inputs steer the A detour and never gate this node
`include "maze_node_config.svh"

module maze_node #(
    parameter maze_node_pkg::coord_t HP = `MAZE_DEF_HP,  // Column
    parameter maze_node_pkg::coord_t VP = `MAZE_DEF_VP   // Row
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    // Local injection
    input  logic                        a_vld_i,
    input  logic                        a_qos_i,
    input  logic [1:0]                  a_type_i,
    input  maze_node_pkg::node_t        a_src_i,
    input  maze_node_pkg::node_t        a_tgt_i,
    input  logic [`MAZE_DATA_W-1:0]     a_data_i,
    output logic                        a_rdy_o,
    // Row link in
    input  logic                        x_in_vld_i,
    input  logic                        x_in_qos_i,
    input  logic [1:0]                  x_in_type_i,
    input  maze_node_pkg::node_t        x_in_src_i,
    input  maze_node_pkg::node_t        x_in_tgt_i,
    input  logic [`MAZE_DATA_W-1:0]     x_in_data_i,
    output logic                        x_in_rdy_o,
    // Column link in
    input  logic                        y_in_vld_i,
    input  logic                        y_in_qos_i,
    input  logic [1:0]                  y_in_type_i,
    input  maze_node_pkg::node_t        y_in_src_i,
    input  maze_node_pkg::node_t        y_in_tgt_i,
    input  logic [`MAZE_DATA_W-1:0]     y_in_data_i,
    output logic                        y_in_rdy_o,
    // Local ejection
    output logic                        b_vld_o,
    output logic                        b_qos_o,
    output logic [1:0]                  b_type_o,
    output maze_node_pkg::node_t        b_src_o,
    output maze_node_pkg::node_t        b_tgt_o,
    output logic [`MAZE_DATA_W-1:0]     b_data_o,
    input  logic                        b_rdy_i,
    // Row link out
    output logic                        x_out_vld_o,
    output logic                        x_out_qos_o,
    output logic [1:0]                  x_out_type_o,
    output maze_node_pkg::node_t        x_out_src_o,
    output maze_node_pkg::node_t        x_out_tgt_o,
    output logic [`MAZE_DATA_W-1:0]     x_out_data_o,
    input  logic                        x_out_rdy_i,
    // Column link out
    output logic                        y_out_vld_o,
    output logic                        y_out_qos_o,
    output logic [1:0]                  y_out_type_o,
    output maze_node_pkg::node_t        y_out_src_o,
    output maze_node_pkg::node_t        y_out_tgt_o,
    output logic [`MAZE_DATA_W-1:0]     y_out_data_o,
    input  logic                        y_out_rdy_i,
    // Power-gated node report
    input  logic                        pg_en_i,
    input  maze_node_pkg::node_t        pg_node_i
);

    import maze_node_pkg::*;

    pkt_t      a_pkt, x_pkt, y_pkt;        // Packed arrivals
    logic      a_hvld, x_hvld, y_hvld;     // Input heads
    pkt_t      a_hpkt, x_hpkt, y_hpkt;
    out_port_e a_dest, x_dest, y_dest;
    logic      a_pop, x_pop, y_pop;
    logic      b_push, xo_push, yo_push;   // Into output buffers
    pkt_t      b_wpkt, xo_wpkt, yo_wpkt;
    logic      b_full, xo_full, yo_full;
    pkt_t      b_pkt, xo_pkt, yo_pkt;      // Output heads

    assign a_pkt = '{pkt_type: a_type_i, qos: a_qos_i, src: a_src_i, tgt: a_tgt_i,
                     data: a_data_i};
    assign x_pkt = '{pkt_type: x_in_type_i, qos: x_in_qos_i, src: x_in_src_i,
                     tgt: x_in_tgt_i, data: x_in_data_i};
    assign y_pkt = '{pkt_type: y_in_type_i, qos: y_in_qos_i, src: y_in_src_i,
                     tgt: y_in_tgt_i, data: y_in_data_i};

    // ======================================================================
    // Ingress side
    // ======================================================================

    ingress_port #(.IS_LOCAL(1'b1), .HP(HP), .VP(VP)) u_ing_a (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .in_vld_i(a_vld_i), .in_pkt_i(a_pkt), .in_rdy_o(a_rdy_o),
        .pg_en_i(pg_en_i), .pg_node_i(pg_node_i),
        .head_vld_o(a_hvld), .head_pkt_o(a_hpkt), .head_dest_o(a_dest), .pop_i(a_pop)
    );

    ingress_port #(.IS_LOCAL(1'b0), .HP(HP), .VP(VP)) u_ing_x (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .in_vld_i(x_in_vld_i), .in_pkt_i(x_pkt), .in_rdy_o(x_in_rdy_o),
        .pg_en_i(pg_en_i), .pg_node_i(pg_node_i),
        .head_vld_o(x_hvld), .head_pkt_o(x_hpkt), .head_dest_o(x_dest), .pop_i(x_pop)
    );

    ingress_port #(.IS_LOCAL(1'b0), .HP(HP), .VP(VP)) u_ing_y (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .in_vld_i(y_in_vld_i), .in_pkt_i(y_pkt), .in_rdy_o(y_in_rdy_o),
        .pg_en_i(pg_en_i), .pg_node_i(pg_node_i),
        .head_vld_o(y_hvld), .head_pkt_o(y_hpkt), .head_dest_o(y_dest), .pop_i(y_pop)
    );

    // ======================================================================
    // Switch
    // ======================================================================

    switch_core u_switch (
        .a_vld_i(a_hvld), .a_pkt_i(a_hpkt), .a_dest_i(a_dest),
        .x_vld_i(x_hvld), .x_pkt_i(x_hpkt), .x_dest_i(x_dest),
        .y_vld_i(y_hvld), .y_pkt_i(y_hpkt), .y_dest_i(y_dest),
        .a_pop_o(a_pop), .x_pop_o(x_pop), .y_pop_o(y_pop),
        .b_push_o(b_push), .b_pkt_o(b_wpkt), .b_full_i(b_full),
        .xo_push_o(xo_push), .xo_pkt_o(xo_wpkt), .xo_full_i(xo_full),
        .yo_push_o(yo_push), .yo_pkt_o(yo_wpkt), .yo_full_i(yo_full)
    );

    // ======================================================================
    // Output buffers, write side always has room when pushed
    // ======================================================================

    pkt_fifo #(.DEPTH(`MAZE_OUT_DEPTH)) u_out_b (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .wr_vld_i(b_push), .wr_pkt_i(b_wpkt), .wr_rdy_o(),
        .rd_vld_o(b_vld_o), .rd_pkt_o(b_pkt), .rd_rdy_i(b_rdy_i), .full_o(b_full)
    );

    pkt_fifo #(.DEPTH(`MAZE_OUT_DEPTH)) u_out_x (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .wr_vld_i(xo_push), .wr_pkt_i(xo_wpkt), .wr_rdy_o(),
        .rd_vld_o(x_out_vld_o), .rd_pkt_o(xo_pkt), .rd_rdy_i(x_out_rdy_i), .full_o(xo_full)
    );

    pkt_fifo #(.DEPTH(`MAZE_OUT_DEPTH)) u_out_y (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .wr_vld_i(yo_push), .wr_pkt_i(yo_wpkt), .wr_rdy_o(),
        .rd_vld_o(y_out_vld_o), .rd_pkt_o(yo_pkt), .rd_rdy_i(y_out_rdy_i), .full_o(yo_full)
    );

    // Unpack output heads
    assign b_qos_o      = b_pkt.qos;
    assign b_type_o     = b_pkt.pkt_type;
    assign b_src_o      = b_pkt.src;
    assign b_tgt_o      = b_pkt.tgt;
    assign b_data_o     = b_pkt.data;
    assign x_out_qos_o  = xo_pkt.qos;
    assign x_out_type_o = xo_pkt.pkt_type;
    assign x_out_src_o  = xo_pkt.src;
    assign x_out_tgt_o  = xo_pkt.tgt;
    assign x_out_data_o = xo_pkt.data;
    assign y_out_qos_o  = yo_pkt.qos;
    assign y_out_type_o = yo_pkt.pkt_type;
    assign y_out_src_o  = yo_pkt.src;
    assign y_out_tgt_o  = yo_pkt.tgt;
    assign y_out_data_o = yo_pkt.data;

endmodule

//--- hdl/maze_node_config.svh
// Widths fit an 8x8 mesh only; the packet word must equal the sum of the pkt_t fields
`ifndef MAZE_NODE_CONFIG_SVH
`define MAZE_NODE_CONFIG_SVH

// ==========================================================================
// Packet geometry
// ==========================================================================

`define MAZE_COORD_W 3   // One mesh axis, 0..7
`define MAZE_NODE_W 6    // Row on top, column below
`define MAZE_DATA_W 8    // Payload byte
`define MAZE_PKT_W 23    // type 2 + qos 1 + src 6 + tgt 6 + data 8

// ==========================================================================
// Buffering and placement
// ==========================================================================

`define MAZE_IN_DEPTH 2   // Per input link
`define MAZE_OUT_DEPTH 2  // Per output link

// Node position when the parent does not override it
`define MAZE_DEF_HP 3  // Column
`define MAZE_DEF_VP 3  // Row

`endif

//--- hdl/maze_node_pkg.sv
// Types only; the field order of pkt_t fixes the bit layout seen on every link
`include "maze_node_config.svh"

package maze_node_pkg;

    // ======================================================================
    // Addressing
    // ======================================================================

    typedef logic [`MAZE_COORD_W-1:0] coord_t;  // One axis
    typedef logic [`MAZE_NODE_W-1:0] node_t;    // {row, column}

    // ======================================================================
    // Packet word
    // ======================================================================

    typedef struct packed {
        logic [1:0]              pkt_type;  // Passed through untouched
        logic                    qos;       // 1 = high class
        node_t                   src;
        node_t                   tgt;
        logic [`MAZE_DATA_W-1:0] data;
    } pkt_t;

    // Output selected for a head packet
    typedef enum logic [1:0] {
        OUT_B,  // Local ejection
        OUT_X,  // Row link
        OUT_Y   // Column link
    } out_port_e;

    // Requester index, lower wins within a QoS class
    typedef enum logic [1:0] {
        SRC_A,
        SRC_X,
        SRC_Y
    } src_idx_e;

endpackage

//--- hdl/pkt_fifo.sv
// Write ready drops only when full, so a full buffer takes no write even while it is read
`include "maze_node_config.svh"

module pkt_fifo #(
    parameter int DEPTH = `MAZE_IN_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 wr_vld_i,
    input  maze_node_pkg::pkt_t  wr_pkt_i,
    output logic                 wr_rdy_o,
    output logic                 rd_vld_o,
    output maze_node_pkg::pkt_t  rd_pkt_o,
    input  logic                 rd_rdy_i,
    output logic                 full_o
);

    import maze_node_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`MAZE_PKT_W-1:0] mem [DEPTH];  // Payload storage
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   push;
    logic                   pop;

    assign full_o   = (count == CNT_W'(DEPTH));
    assign wr_rdy_o = ~full_o;               // State only
    assign rd_vld_o = (count != '0);
    assign rd_pkt_o = pkt_t'(mem[rd_ptr]);   // Head is always visible

    assign push = wr_vld_i & wr_rdy_o;
    assign pop  = rd_vld_o & rd_rdy_i;

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= wr_pkt_i;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

//--- hdl/qos_arbiter.sv
// Three requesters, fixed priority inside a class, no fairness between equal-class inputs
module qos_arbiter (
    input  logic [2:0] req_i,
    input  logic [2:0] qos_i,    // Per requester class
    input  logic       room_i,   // Output buffer not full
    output logic [2:0] grant_o   // One-hot or zero
);

    always_comb begin
        logic found;

        found   = 1'b0;
        grant_o = '0;

        if (room_i) begin
            // High class first
            for (int i = 0; i < 3; i++) begin
                if (!found && req_i[i] && qos_i[i]) begin
                    grant_o[i] = 1'b1;
                    found      = 1'b1;
                end
            end

            // Then low class, still lowest index
            for (int i = 0; i < 3; i++) begin
                if (!found && req_i[i] && !qos_i[i]) begin
                    grant_o[i] = 1'b1;
                    found      = 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/switch_core.sv
// Single-cycle crossbar; each input names one output, so it wins at most once per cycle
module switch_core (
    input  logic                      a_vld_i,
    input  maze_node_pkg::pkt_t       a_pkt_i,
    input  maze_node_pkg::out_port_e  a_dest_i,
    input  logic                      x_vld_i,
    input  maze_node_pkg::pkt_t       x_pkt_i,
    input  maze_node_pkg::out_port_e  x_dest_i,
    input  logic                      y_vld_i,
    input  maze_node_pkg::pkt_t       y_pkt_i,
    input  maze_node_pkg::out_port_e  y_dest_i,
    output logic                      a_pop_o,
    output logic                      x_pop_o,
    output logic                      y_pop_o,
    output logic                      b_push_o,
    output maze_node_pkg::pkt_t       b_pkt_o,
    input  logic                      b_full_i,
    output logic                      xo_push_o,
    output maze_node_pkg::pkt_t       xo_pkt_o,
    input  logic                      xo_full_i,
    output logic                      yo_push_o,
    output maze_node_pkg::pkt_t       yo_pkt_o,
    input  logic                      yo_full_i
);

    import maze_node_pkg::*;

    logic [2:0] in_vld;
    logic [2:0] in_qos;
    pkt_t       in_pkt  [3];   // Indexed by src_idx_e
    out_port_e  in_dest [3];
    logic [2:0] out_full;      // Indexed by out_port_e
    logic [2:0] out_push;
    pkt_t       out_pkt [3];
    logic [2:0] grant   [3];   // grant[output][input]

    // ======================================================================
    // Gather inputs and outputs into arrays
    // ======================================================================

    assign in_vld = {y_vld_i, x_vld_i, a_vld_i};
    assign in_pkt[SRC_A] = a_pkt_i;
    assign in_pkt[SRC_X] = x_pkt_i;
    assign in_pkt[SRC_Y] = y_pkt_i;
    assign in_dest[SRC_A] = a_dest_i;
    assign in_dest[SRC_X] = x_dest_i;
    assign in_dest[SRC_Y] = y_dest_i;
    assign in_qos = {y_pkt_i.qos, x_pkt_i.qos, a_pkt_i.qos};

    assign out_full = {yo_full_i, xo_full_i, b_full_i};

    // ======================================================================
    // One arbiter and data select per output
    // ======================================================================

    for (genvar o = 0; o < 3; o++) begin : g_out
        logic [2:0] req;

        for (genvar i = 0; i < 3; i++) begin : g_req
            assign req[i] = in_vld[i] && (in_dest[i] == out_port_e'(o));
        end

        qos_arbiter u_arb (
            .req_i   (req),
            .qos_i   (in_qos),
            .room_i  (~out_full[o]),
            .grant_o (grant[o])
        );

        assign out_push[o] = |grant[o];

        always_comb begin
            out_pkt[o] = in_pkt[SRC_A];  // Don't care when no grant
            for (int i = 0; i < 3; i++) begin
                if (grant[o][i]) begin
                    out_pkt[o] = in_pkt[i];
                end
            end
        end
    end

    // An input leaves its buffer on the edge its head is pushed
    assign a_pop_o = grant[OUT_B][SRC_A] | grant[OUT_X][SRC_A] | grant[OUT_Y][SRC_A];
    assign x_pop_o = grant[OUT_B][SRC_X] | grant[OUT_X][SRC_X] | grant[OUT_Y][SRC_X];
    assign y_pop_o = grant[OUT_B][SRC_Y] | grant[OUT_X][SRC_Y] | grant[OUT_Y][SRC_Y];

    assign b_push_o  = out_push[OUT_B];
    assign b_pkt_o   = out_pkt[OUT_B];
    assign xo_push_o = out_push[OUT_X];
    assign xo_pkt_o  = out_pkt[OUT_X];
    assign yo_push_o = out_push[OUT_Y];
    assign yo_pkt_o  = out_pkt[OUT_Y];

endmodule

//--- project.f
+incdir+hdl
hdl/maze_node_pkg.sv
hdl/pkt_fifo.sv
hdl/ingress_port.sv
hdl/qos_arbiter.sv
hdl/switch_core.sv
hdl/maze_node.sv
sim/tb_maze_node.sv

//--- sim/tb_maze_node.sv
// Built for HP=VP=3 only; pg inputs are held steady while packets of a test are in flight
module tb_maze_node;
    timeunit 1ns;
    timeprecision 1ps;

    import maze_node_pkg::*;

    localparam coord_t HP      = 3;
    localparam coord_t VP      = 3;
    localparam int     N_PKT   = 170;              // Upper bound over all tests
    localparam int     TIMEOUT = 8 * N_PKT + 200;  // Cycles

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    logic [2:0]  in_vld;       // Index 0 = A, 1 = X in, 2 = Y in
    pkt_t        in_pkt [3];
    logic [2:0]  in_rdy;
    logic [2:0]  out_vld;      // Index follows out_port_e
    pkt_t        out_pkt [3];
    logic [2:0]  out_rdy;
    logic        pg_en;
    node_t       pg_node;

    logic [7:0]  lfsr = 8'd61;
    pkt_t        pend_q [3][$];  // Waiting to be driven, per input
    pkt_t        exp_q [9][$];   // Expected, [out * 3 + in]
    out_port_e   dest_of [256];  // Expected output by sequence tag
    pkt_t        y_seen [$];     // Y output order capture
    logic        rec_y;
    logic        rand_rdy;
    logic        rand_vld;
    int          n_err;
    int          n_chk;
    int          n_wait;
    int          cyc;
    int          seq;
    string       out_name [3] = '{"b", "x_out", "y_out"};

    maze_node #(.HP(HP), .VP(VP)) uut (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .a_vld_i(in_vld[0]), .a_qos_i(in_pkt[0].qos), .a_type_i(in_pkt[0].pkt_type),
        .a_src_i(in_pkt[0].src), .a_tgt_i(in_pkt[0].tgt), .a_data_i(in_pkt[0].data),
        .a_rdy_o(in_rdy[0]),
        .x_in_vld_i(in_vld[1]), .x_in_qos_i(in_pkt[1].qos), .x_in_type_i(in_pkt[1].pkt_type),
        .x_in_src_i(in_pkt[1].src), .x_in_tgt_i(in_pkt[1].tgt), .x_in_data_i(in_pkt[1].data),
        .x_in_rdy_o(in_rdy[1]),
        .y_in_vld_i(in_vld[2]), .y_in_qos_i(in_pkt[2].qos), .y_in_type_i(in_pkt[2].pkt_type),
        .y_in_src_i(in_pkt[2].src), .y_in_tgt_i(in_pkt[2].tgt), .y_in_data_i(in_pkt[2].data),
        .y_in_rdy_o(in_rdy[2]),
        .b_vld_o(out_vld[0]), .b_qos_o(out_pkt[0].qos), .b_type_o(out_pkt[0].pkt_type),
        .b_src_o(out_pkt[0].src), .b_tgt_o(out_pkt[0].tgt), .b_data_o(out_pkt[0].data),
        .b_rdy_i(out_rdy[0]),
        .x_out_vld_o(out_vld[1]), .x_out_qos_o(out_pkt[1].qos),
        .x_out_type_o(out_pkt[1].pkt_type), .x_out_src_o(out_pkt[1].src),
        .x_out_tgt_o(out_pkt[1].tgt), .x_out_data_o(out_pkt[1].data),
        .x_out_rdy_i(out_rdy[1]),
        .y_out_vld_o(out_vld[2]), .y_out_qos_o(out_pkt[2].qos),
        .y_out_type_o(out_pkt[2].pkt_type), .y_out_src_o(out_pkt[2].src),
        .y_out_tgt_o(out_pkt[2].tgt), .y_out_data_o(out_pkt[2].data),
        .y_out_rdy_i(out_rdy[2]),
        .pg_en_i(pg_en), .pg_node_i(pg_node)
    );

    always #50 clk_i = ~clk_i;  // 100 ns period

    // ======================================================================
    // Random source, reference model and compare tasks
    // ======================================================================

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic lfsr_bit();
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        return lfsr[0];
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    // src marks the input, data carries the sequence tag
    function automatic pkt_t mk_pkt(input int in, input node_t tgt, input logic qos);
        pkt_t p;
        p.pkt_type = 2'(rand_bits(2));
        p.qos      = qos;
        p.src      = node_t'(in);
        p.tgt      = tgt;
        p.data     = seq[7:0];
        seq++;
        return p;
    endfunction

    function automatic out_port_e route(input pkt_t p, input bit local_in);
        coord_t tx;
        coord_t ty;
        logic   g1;
        logic   g2;
        tx = p.tgt[2:0];
        ty = p.tgt[5:3];
        if (tx == HP && ty == VP) return OUT_B;
        if (!local_in) return (tx != HP) ? OUT_X : OUT_Y;   // Link rule
        g1 = pg_en && (pg_node == {VP, tx});
        g2 = pg_en && (pg_node == {ty, HP});
        if (!g1) return (tx != HP) ? OUT_X : OUT_Y;         // Row-first hop
        if (!g2) return OUT_Y;                              // Column-first hop
        return (tx != HP) ? OUT_X : OUT_Y;                  // Both gated, direct
    endfunction

    task automatic check_pkt(input string name, input pkt_t got, input pkt_t exp);
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_dest(input string name, input out_port_e got, input out_port_e exp);
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    // ======================================================================
    // Drivers and scoreboard
    // ======================================================================

    always @(posedge clk_i) begin
        pkt_t      p;
        out_port_e e;
        int        k;
        if (arst_n_i) begin
            for (int i = 0; i < 3; i++) begin
                if (in_vld[i] && in_rdy[i]) begin        // Accepted this edge
                    e = route(in_pkt[i], i == 0);
                    dest_of[in_pkt[i].data] = e;
                    exp_q[int'(e) * 3 + i].push_back(in_pkt[i]);
                    void'(pend_q[i].pop_front());
                end
                if (!(in_vld[i] && !in_rdy[i])) begin    // Not holding a packet
                    if (pend_q[i].size() > 0 && (!rand_vld || lfsr_bit())) begin
                        in_vld[i] <= 1'b1;
                        in_pkt[i] <= pend_q[i][0];
                    end else begin
                        in_vld[i] <= 1'b0;
                    end
                end
            end
            for (int o = 0; o < 3; o++) begin
                if (out_vld[o] && out_rdy[o]) begin
                    p = out_pkt[o];
                    n_chk++;
                    e = dest_of[p.data];
                    k = int'(e) * 3 + int'(p.src);
                    check_dest({out_name[o], " port"}, out_port_e'(o), e);
                    if (p.src > 2 || exp_q[k].size() == 0) begin
                        n_err++;
                        $display("Packet on %s with tag %0d was never expected",
                                 out_name[o], p.data);
                    end else begin
                        check_pkt({out_name[o], " pkt"}, p, exp_q[k].pop_front());
                    end
                    if (o == 2 && rec_y) y_seen.push_back(p);
                end
            end
            if (rand_rdy) out_rdy <= {lfsr_bit(), lfsr_bit(), lfsr_bit()};
        end
    end

    always @(posedge clk_i) begin
        cyc++;
        if (cyc > TIMEOUT) begin
            $display("Run stopped, no progress after %0d cycles", cyc);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic bit idle();
        for (int i = 0; i < 3; i++) if (pend_q[i].size() != 0) return 1'b0;
        for (int k = 0; k < 9; k++) if (exp_q[k].size() != 0) return 1'b0;
        return (in_vld == 3'b000);
    endfunction

    task automatic drain(input string name);
        @(negedge clk_i);
        while (!idle()) @(negedge clk_i);
        repeat (3) @(negedge clk_i);
        $display("%-10s done, %0d checked, %0d errors so far", name, n_chk, n_err);
    endtask

    task automatic wait_sent();
        @(negedge clk_i);
        while (pend_q[0].size() + pend_q[1].size() + pend_q[2].size() != 0 || in_vld != 0)
            @(negedge clk_i);
        repeat (4) @(negedge clk_i);
    endtask

    // Two Y-in fillers block the Y output, then A and X heads contend for it
    task automatic order_round(input logic qa, input logic qx, input bit x_first);
        pkt_t exp_ord [$];
        pkt_t pa;
        pkt_t px;
        @(posedge clk_i);
        out_rdy[2] <= 1'b0;
        for (int k = 0; k < 2; k++) begin
            exp_ord.push_back(mk_pkt(2, {3'd5, HP}, lfsr_bit()));
            pend_q[2].push_back(exp_ord[k]);
        end
        wait_sent();
        pa = mk_pkt(0, {3'd5, HP}, qa);
        px = mk_pkt(1, {3'd5, HP}, qx);
        pend_q[0].push_back(pa);
        pend_q[1].push_back(px);
        wait_sent();
        if (x_first) begin
            exp_ord.push_back(px);
            exp_ord.push_back(pa);
        end else begin
            exp_ord.push_back(pa);
            exp_ord.push_back(px);
        end
        y_seen.delete();
        rec_y = 1'b1;
        @(posedge clk_i);
        out_rdy[2] <= 1'b1;
        drain(x_first ? "qos_high" : "qos_equal");
        rec_y = 1'b0;
        if (y_seen.size() != 4) begin
            n_err++;
            $display("Y output gave %0d packets in the order run, 4 wanted", y_seen.size());
        end else begin
            for (int k = 0; k < 4; k++) check_pkt("y_out order", y_seen[k], exp_ord[k]);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        in_vld   = '0;
        out_rdy  = 3'b111;
        pg_en    = 1'b0;
        pg_node  = '0;
        rec_y    = 1'b0;
        rand_rdy = 1'b0;
        rand_vld = 1'b0;
        n_err    = 0;
        n_chk    = 0;
        n_wait   = 0;
        cyc      = 0;
        seq      = 0;
        for (int i = 0; i < 3; i++) in_pkt[i] = '0;
        arst_n_i = 1'b0;
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        if (in_rdy != 3'b111 || out_vld != 3'b000) begin
            n_err++;
            $display("After reset the ready outputs are not all high or a valid is set");
        end

        // 1: local delivery
        for (int k = 0; k < 4; k++) pend_q[0].push_back(mk_pkt(0, {VP, HP}, lfsr_bit()));
        drain("a_local");

        // 2: no gating, row-first
        pend_q[0].push_back(mk_pkt(0, {VP, 3'd0}, 1'b0));
        pend_q[0].push_back(mk_pkt(0, {VP, 3'd6}, 1'b1));
        pend_q[0].push_back(mk_pkt(0, {3'd1, HP}, 1'b0));
        pend_q[0].push_back(mk_pkt(0, {3'd7, HP}, 1'b1));
        for (int k = 0; k < 4; k++) begin
            pend_q[0].push_back(mk_pkt(0, node_t'(rand_bits(6)), 1'b0));
        end
        drain("a_route");

        // 3: first node gated, then only the second, then both
        @(posedge clk_i);
        pg_en   <= 1'b1;
        pg_node <= {VP, 3'd1};
        for (int k = 0; k < 4; k++) pend_q[0].push_back(mk_pkt(0, {3'(2 * k), 3'd1}, 1'b0));
        wait_sent();
        @(posedge clk_i);
        pg_node <= {3'd5, HP};
        pend_q[0].push_back(mk_pkt(0, {3'd5, 3'd1}, 1'b1));
        pend_q[0].push_back(mk_pkt(0, {3'd5, 3'd6}, 1'b0));
        wait_sent();
        @(posedge clk_i);
        pg_node <= {VP, HP};
        pend_q[0].push_back(mk_pkt(0, {VP, HP}, 1'b0));
        drain("a_gated");

        // 4: link rule on both inputs
        @(posedge clk_i);
        pg_en <= 1'b0;
        for (int i = 1; i < 3; i++) begin
            pend_q[i].push_back(mk_pkt(i, {VP, HP}, 1'b0));
            pend_q[i].push_back(mk_pkt(i, {VP, 3'd5}, 1'b1));
            pend_q[i].push_back(mk_pkt(i, {3'd5, HP}, 1'b0));
            pend_q[i].push_back(mk_pkt(i, node_t'(rand_bits(6)), 1'b1));
        end
        drain("link");

        // 5: arbitration order
        order_round(1'b0, 1'b1, 1'b1);
        order_round(1'b1, 1'b1, 1'b0);

        // 6: blocked A input, then random traffic
        @(posedge clk_i);
        out_rdy <= 3'b000;
        pg_en   <= 1'b1;
        pg_node <= node_t'(rand_bits(6));
        for (int k = 0; k < 6; k++) pend_q[0].push_back(mk_pkt(0, {VP, HP}, 1'b0));
        @(negedge clk_i);
        // Two input and two output entries fill before a_rdy_o drops
        while (in_rdy[0] && n_wait < 20) begin
            @(negedge clk_i);
            n_wait++;
        end
        if (in_rdy[0]) begin
            n_err++;
            $display("a_rdy_o stayed high with all outputs blocked");
        end else if (pend_q[0].size() != 2) begin
            n_err++;
            $display("a_rdy_o fell after %0d accepted packets, 4 wanted",
                     6 - pend_q[0].size());
        end
        rand_rdy = 1'b1;
        rand_vld = 1'b1;
        for (int k = 0; k < 40; k++) begin
            for (int i = 0; i < 3; i++) begin
                pend_q[i].push_back(mk_pkt(i, node_t'(rand_bits(6)), lfsr_bit()));
            end
        end
        drain("random");
        rand_rdy = 1'b0;
        rand_vld = 1'b0;

        $display("Checked %0d packets, %0d errors", n_chk, n_err);
        if (n_err == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
